//--- src/rvd_consts.svh
// Encodings and timing constants for the RV32 decode stage
// Include at the top of any RTL file that matches opcode or funct fields

`ifndef RVD_CONSTS_SVH
`define RVD_CONSTS_SVH

// Major opcodes, bits [6:0] of the word
`define RVD_OPC_OP       7'b0110011
`define RVD_OPC_OP_IMM   7'b0010011
`define RVD_OPC_LUI      7'b0110111
`define RVD_OPC_SYSTEM   7'b1110011

// funct7 variants
`define RVD_F7_BASE      7'b0000000  // Plain ALU op and SRLI/SLLI
`define RVD_F7_ALT       7'b0100000  // SUB, SRA, SRAI
`define RVD_F7_MULDIV    7'b0000001  // M extension

// funct3 for integer ALU ops
`define RVD_F3_ADD       3'b000      // ADD and SUB share it
`define RVD_F3_SLL       3'b001
`define RVD_F3_SLT       3'b010
`define RVD_F3_SLTU      3'b011
`define RVD_F3_XOR       3'b100
`define RVD_F3_SRL       3'b101      // SRL and SRA share it
`define RVD_F3_OR        3'b110
`define RVD_F3_AND       3'b111

// SYSTEM immediates, rs1, rd and funct3 all zero
`define RVD_IMM_ECALL    12'h000
`define RVD_IMM_EBREAK   12'h001

// Cycles the input is held off after an accepted MUL/DIV, 1 or more
`define RVD_MD_CYCLES    4

`endif

//--- src/rvd_pkg.sv
// Types shared by the decode stage
// Instruction word views, operator enums, decode control bundle, FSM states

`default_nettype none

package rvd_pkg;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////

  // Register form, OP and OP-IMM shift checks
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Immediate form, OP-IMM and SYSTEM
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // One word, decoded by opcode either way
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  //////////////////////////////
  // Operators
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  // Encoded as funct3 so the M decoder casts directly
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  // Control bundle produced by every sub-decoder
  typedef struct packed {
    logic    alu_en;
    alu_op_e alu_operator;
    logic    alu_use_imm;  // Operand b from immediate
    logic    md_en;
    md_op_e  md_operator;
    logic    rf_we;
    logic    ecall_insn;
    logic    ebrk_insn;
    logic    illegal_insn;
  } decoder_ctrl_t;

  // No match, nothing enabled
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_en:       1'b0,
    alu_operator: ALU_ADD,
    alu_use_imm:  1'b0,
    md_en:        1'b0,
    md_operator:  MD_MUL,
    rf_we:        1'b0,
    ecall_insn:   1'b0,
    ebrk_insn:    1'b0,
    illegal_insn: 1'b1
  };

  typedef enum logic [1:0] {
    CTRL_RUN,
    CTRL_MD_WAIT,
    CTRL_TRAP
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/rvd_i_decoder.sv
// Base integer decoder for OP, OP-IMM, LUI, ECALL and EBREAK
// Purely combinational, returns the illegal bundle on no match

`timescale 1ns/1ps
`default_nettype none

`include "rvd_consts.svh"

module rvd_i_decoder (
  input  rvd_pkg::instr_u        instr_rdata_i,   // Instruction word
  output rvd_pkg::decoder_ctrl_t decoder_ctrl_o   // Base set decode
);
  import rvd_pkg::*;

  logic    legal;     // ALU instruction matched
  alu_op_e alu_op;
  logic    use_imm;
  logic    is_ecall;
  logic    is_ebrk;

  ////////////////////////////////
  // Field match
  ////////////////////////////////

  always_comb begin
    legal    = 1'b0;
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    is_ecall = 1'b0;
    is_ebrk  = 1'b0;

    case (instr_rdata_i.r.opcode)
      `RVD_OPC_OP: begin  // Register form
        if (instr_rdata_i.r.funct7 == `RVD_F7_BASE) begin
          legal = 1'b1;
          case (instr_rdata_i.r.funct3)
            `RVD_F3_ADD:  alu_op = ALU_ADD;
            `RVD_F3_SLL:  alu_op = ALU_SLL;
            `RVD_F3_SLT:  alu_op = ALU_SLT;
            `RVD_F3_SLTU: alu_op = ALU_SLTU;
            `RVD_F3_XOR:  alu_op = ALU_XOR;
            `RVD_F3_SRL:  alu_op = ALU_SRL;
            `RVD_F3_OR:   alu_op = ALU_OR;
            default:      alu_op = ALU_AND;
          endcase
        end else if (instr_rdata_i.r.funct7 == `RVD_F7_ALT) begin
          // Only SUB and SRA have the alternate funct7
          if (instr_rdata_i.r.funct3 == `RVD_F3_ADD) begin
            legal  = 1'b1;
            alu_op = ALU_SUB;
          end else if (instr_rdata_i.r.funct3 == `RVD_F3_SRL) begin
            legal  = 1'b1;
            alu_op = ALU_SRA;
          end
        end
      end
      `RVD_OPC_OP_IMM: begin  // Immediate form
        legal   = 1'b1;
        use_imm = 1'b1;
        case (instr_rdata_i.i.funct3)
          `RVD_F3_ADD:  alu_op = ALU_ADD;
          `RVD_F3_SLT:  alu_op = ALU_SLT;
          `RVD_F3_SLTU: alu_op = ALU_SLTU;
          `RVD_F3_XOR:  alu_op = ALU_XOR;
          `RVD_F3_OR:   alu_op = ALU_OR;
          `RVD_F3_AND:  alu_op = ALU_AND;
          `RVD_F3_SLL: begin
            alu_op = ALU_SLL;
            legal  = (instr_rdata_i.i.imm[11:5] == `RVD_F7_BASE);  // Upper imm bits fixed
          end
          default: begin  // SRLI or SRAI
            if (instr_rdata_i.i.imm[11:5] == `RVD_F7_BASE) alu_op = ALU_SRL;
            else if (instr_rdata_i.i.imm[11:5] == `RVD_F7_ALT) alu_op = ALU_SRA;
            else legal = 1'b0;
          end
        endcase
      end
      `RVD_OPC_LUI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        alu_op  = ALU_LUI;  // Upper immediate passes through ALU
      end
      `RVD_OPC_SYSTEM: begin
        if (instr_rdata_i.i.rs1 == 5'd0 && instr_rdata_i.i.rd == 5'd0 &&
            instr_rdata_i.i.funct3 == 3'b000) begin
          is_ecall = (instr_rdata_i.i.imm == `RVD_IMM_ECALL);
          is_ebrk  = (instr_rdata_i.i.imm == `RVD_IMM_EBREAK);
        end
      end
      default: ;  // Anything else stays illegal
    endcase
  end

  ////////////////////////////////
  // Control bundle
  ////////////////////////////////

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
    if (legal) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.alu_en       = 1'b1;
      decoder_ctrl_o.alu_operator = alu_op;
      decoder_ctrl_o.alu_use_imm  = use_imm;
      decoder_ctrl_o.rf_we        = 1'b1;
    end else if (is_ecall || is_ebrk) begin
      decoder_ctrl_o.illegal_insn = 1'b0;  // No writeback, trap flags only
      decoder_ctrl_o.ecall_insn   = is_ecall;
      decoder_ctrl_o.ebrk_insn    = is_ebrk;
    end
  end

endmodule

`default_nettype wire

//--- src/rvd_m_decoder.sv
// M extension decoder, multiply and divide in the OP opcode space
// Purely combinational, marks every other word illegal

`timescale 1ns/1ps
`default_nettype none

`include "rvd_consts.svh"

module rvd_m_decoder (
  input  rvd_pkg::instr_u        instr_rdata_i,   // Instruction word
  output rvd_pkg::decoder_ctrl_t decoder_ctrl_o   // M extension decode
);
  import rvd_pkg::*;

  logic md_match;  // OP opcode with the MULDIV funct7

  assign md_match = (instr_rdata_i.r.opcode == `RVD_OPC_OP) &&
                    (instr_rdata_i.r.funct7 == `RVD_F7_MULDIV);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
    if (md_match) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.md_en        = 1'b1;
      decoder_ctrl_o.md_operator  = md_op_e'(instr_rdata_i.r.funct3);  // Enum follows funct3
      decoder_ctrl_o.rf_we        = 1'b1;   // Result always written back
    end
  end

endmodule

`default_nettype wire

//--- src/rvd_decoder.sv
// Decoder wrapper around the base and M sub-decoders
// Picks the matching result, applies the compressed-illegal flag
// and clears enables and flags while the controller deasserts

`timescale 1ns/1ps
`default_nettype none

module rvd_decoder (
  input  rvd_pkg::instr_u        instr_rdata_i,     // Word at the input port
  input  logic                   illegal_c_insn_i,  // Compressed expansion failed
  input  logic                   deassert_i,        // Trap mode from controller
  output rvd_pkg::decoder_ctrl_t decoder_ctrl_o,    // Suppressed result
  output logic                   raw_trap_o,        // Illegal, ECALL or EBREAK before suppression
  output logic                   raw_md_o           // MUL/DIV before suppression
);
  import rvd_pkg::*;

  decoder_ctrl_t ctrl_i;    // Base set result
  decoder_ctrl_t ctrl_m;    // M extension result
  decoder_ctrl_t ctrl_mux;  // Selected, before suppression

  rvd_i_decoder u_i_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (ctrl_i)
  );

  rvd_m_decoder u_m_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (ctrl_m)
  );

  // Priority select, compressed failure overrides both
  always_comb begin
    if (illegal_c_insn_i) begin
      ctrl_mux = DECODER_CTRL_ILLEGAL;
    end else if (!ctrl_m.illegal_insn) begin
      ctrl_mux = ctrl_m;  // M decoder matched
    end else begin
      ctrl_mux = ctrl_i;  // Base result, illegal when neither matched
    end
  end

  assign raw_trap_o = ctrl_mux.illegal_insn | ctrl_mux.ecall_insn | ctrl_mux.ebrk_insn;
  assign raw_md_o   = ctrl_mux.md_en;

  // Suppress enables and flags, operators pass unchanged
  always_comb begin
    decoder_ctrl_o = ctrl_mux;
    if (deassert_i) begin
      decoder_ctrl_o.alu_en       = 1'b0;
      decoder_ctrl_o.md_en        = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b0;
      decoder_ctrl_o.ecall_insn   = 1'b0;
      decoder_ctrl_o.ebrk_insn    = 1'b0;
      decoder_ctrl_o.illegal_insn = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rvd_ctrl_fsm.sv
// Decode stage controller
// RUN issues normally, MD_WAIT holds the input off while the busy
// counter runs, TRAP issues with controls cleared until a flush

`timescale 1ns/1ps
`default_nettype none

module rvd_ctrl_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic accept_i,         // Input transfer this cycle
  input  logic raw_trap_i,       // Accepted word traps
  input  logic raw_md_i,         // Accepted word is MUL/DIV
  input  logic counter_done_i,   // Last stall cycle
  input  logic flush_i,          // Leave trap mode
  output logic counter_start_o,  // Load busy counter
  output logic issue_en_o,       // Input may be accepted
  output logic deassert_o        // Clear decoded controls
);
  import rvd_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_RUN: begin
        if (accept_i && raw_md_i)        state_d = CTRL_MD_WAIT;
        else if (accept_i && raw_trap_i) state_d = CTRL_TRAP;
      end
      CTRL_MD_WAIT: begin
        if (counter_done_i) state_d = CTRL_RUN;
      end
      CTRL_TRAP: begin
        if (flush_i) state_d = CTRL_RUN;  // Stays until flushed
      end
      default: state_d = CTRL_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CTRL_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Counter loads on the same edge that enters MD_WAIT
  assign counter_start_o = (state_q == CTRL_RUN) && accept_i && raw_md_i;
  assign issue_en_o      = (state_q == CTRL_RUN) || (state_q == CTRL_TRAP);
  assign deassert_o      = (state_q == CTRL_TRAP);

endmodule

`default_nettype wire

//--- src/rvd_busy_counter.sv
// Multiply/divide stall timer
// Loads the stall length on start, counts to zero, flags the last count

`timescale 1ns/1ps
`default_nettype none

`include "rvd_consts.svh"

module rvd_busy_counter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,  // Load stall length
  output logic done_o    // High in the final stall cycle
);

  localparam int CW = $clog2(`RVD_MD_CYCLES + 1);  // Holds the full count

  logic [CW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CW'(`RVD_MD_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;  // Idle at zero
    end
  end

  // Count of one is the last cycle before the FSM leaves MD_WAIT
  assign done_o = (cnt_q == CW'(1));

endmodule

`default_nettype wire

//--- src/rvd_id_stage.sv
// Instruction decode stage top level
// Valid/ready instruction input, decoder, controller and stall timer,
// decoded controls leave through one registered valid/ready slot

`timescale 1ns/1ps
`default_nettype none

`include "rvd_consts.svh"

module rvd_id_stage (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              instr_valid_i,
  input  rvd_pkg::instr_u   instr_rdata_i,
  input  logic              illegal_c_insn_i,
  output logic              instr_ready_o,
  output logic              ex_valid_o,
  input  logic              ex_ready_i,
  output logic              alu_en_o,
  output rvd_pkg::alu_op_e  alu_operator_o,
  output logic              alu_use_imm_o,
  output logic [31:0]       imm_o,           // Sign-extended I imm or U imm for LUI
  output logic [4:0]        rs1_o,
  output logic [4:0]        rs2_o,
  output logic [4:0]        rd_o,
  output logic              rf_we_o,
  output logic              md_en_o,
  output rvd_pkg::md_op_e   md_operator_o,
  output logic              illegal_insn_o,
  output logic              ecall_insn_o,
  output logic              ebrk_insn_o,
  input  logic              flush_i          // One-cycle trap exit
);
  import rvd_pkg::*;

  decoder_ctrl_t dec_ctrl;    // Suppressed decode of the input word
  decoder_ctrl_t ex_ctrl_q;   // Output slot controls
  logic          raw_trap, raw_md;
  logic          deassert, issue_en;
  logic          cnt_start, cnt_done;
  logic          out_room;    // Slot empty or draining this cycle
  logic          accept;
  logic          ex_valid_q;
  logic [31:0]   imm_d, imm_q;
  logic [4:0]    rs1_q, rs2_q, rd_q;

  rvd_decoder u_decoder (
    .instr_rdata_i    (instr_rdata_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .deassert_i       (deassert),
    .decoder_ctrl_o   (dec_ctrl),
    .raw_trap_o       (raw_trap),
    .raw_md_o         (raw_md)
  );

  rvd_ctrl_fsm u_ctrl_fsm (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .accept_i        (accept),
    .raw_trap_i      (raw_trap),
    .raw_md_i        (raw_md),
    .counter_done_i  (cnt_done),
    .flush_i         (flush_i),
    .counter_start_o (cnt_start),
    .issue_en_o      (issue_en),
    .deassert_o      (deassert)
  );

  rvd_busy_counter u_busy_counter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (cnt_start),
    .done_o   (cnt_done)
  );

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign out_room      = !ex_valid_q || ex_ready_i;
  assign instr_ready_o = issue_en && out_room;  // Back-pressure reaches the input
  assign accept        = instr_ready_o && instr_valid_i;

  // U form for LUI, immediate form otherwise
  assign imm_d = (instr_rdata_i.r.opcode == `RVD_OPC_LUI) ? {instr_rdata_i[31:12], 12'd0}
                                                           : {{20{instr_rdata_i.i.imm[11]}},
                                                              instr_rdata_i.i.imm};

  //////////////////////////////
  // Output slot
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_q <= 1'b0;
      ex_ctrl_q  <= '0;
    end else if (out_room) begin
      ex_valid_q <= accept;            // Empties when nothing new
      if (accept) ex_ctrl_q <= dec_ctrl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      imm_q <= imm_d;
      rs1_q <= instr_rdata_i.r.rs1;
      rs2_q <= instr_rdata_i.r.rs2;
      rd_q  <= instr_rdata_i.r.rd;
    end
  end

  assign ex_valid_o     = ex_valid_q;
  assign alu_en_o       = ex_ctrl_q.alu_en;
  assign alu_operator_o = ex_ctrl_q.alu_operator;
  assign alu_use_imm_o  = ex_ctrl_q.alu_use_imm;
  assign imm_o          = imm_q;
  assign rs1_o          = rs1_q;
  assign rs2_o          = rs2_q;
  assign rd_o           = rd_q;
  assign rf_we_o        = ex_ctrl_q.rf_we;
  assign md_en_o        = ex_ctrl_q.md_en;
  assign md_operator_o  = ex_ctrl_q.md_operator;
  assign illegal_insn_o = ex_ctrl_q.illegal_insn;
  assign ecall_insn_o   = ex_ctrl_q.ecall_insn;
  assign ebrk_insn_o    = ex_ctrl_q.ebrk_insn;

endmodule

`default_nettype wire

//--- testbench/rvd_chk.sv
// Concurrent checks on the decode stage handshake and control rules
// Attached to every rvd_id_stage by the bind below the module

`timescale 1ns/1ps
`default_nettype none

module rvd_chk (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        instr_ready_i,  // Stage input ready
  input logic        ex_valid_i,
  input logic        ex_ready_i,
  input logic        alu_en_i,
  input logic        md_en_i,
  input logic        rf_we_i,
  input logic        illegal_i,
  input logic        md_start_i,     // MUL/DIV accepted in RUN
  input logic [60:0] fields_i        // Every output field
);

  // Held output keeps valid and all fields
  a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ex_valid_i && !ex_ready_i |=> ex_valid_i && $stable(fields_i))
    else $error("Output changed while ex_ready_i was low");

  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    illegal_i |-> !(alu_en_i || md_en_i || rf_we_i))
    else $error("An enable is high together with illegal_insn_o");

  // Stall starts right after the accept
  a_md_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    md_start_i |=> !instr_ready_i)
    else $error("instr_ready_o high in the cycle after a multiply or divide");

endmodule

bind rvd_id_stage rvd_chk u_chk (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .instr_ready_i (instr_ready_o),
  .ex_valid_i    (ex_valid_o),
  .ex_ready_i    (ex_ready_i),
  .alu_en_i      (alu_en_o),
  .md_en_i       (md_en_o),
  .rf_we_i       (rf_we_o),
  .illegal_i     (illegal_insn_o),
  .md_start_i    (cnt_start),
  .fields_i      ({alu_en_o, alu_operator_o, alu_use_imm_o, imm_o, rs1_o, rs2_o, rd_o,
                   rf_we_o, md_en_o, md_operator_o, illegal_insn_o, ecall_insn_o,
                   ebrk_insn_o})
);

`default_nettype wire

//--- testbench/rvd_tb.sv
// Testbench for the decode stage
// LFSR stimulus, reference decode model and a queue of expected results
// Stops at the first mismatch or when the watchdog runs out

`timescale 1ns/1ps
`default_nettype none

`include "rvd_consts.svh"

module rvd_tb;
  import rvd_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int N_INSTR     = 400;   // Accepted instructions per run
  localparam int WATCHDOG_NS = (N_INSTR * (`RVD_MD_CYCLES + 4) + 4) * CLK_PERIOD;

  // One expected output item
  typedef struct packed {
    logic [31:0]   word;
    decoder_ctrl_t ctrl;
    logic [31:0]   imm;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [4:0]    rd;
  } exp_t;

  logic          clk_i = 1'b0;
  logic          arst_n_i;
  logic          instr_valid_i;
  instr_u        instr_rdata_i;
  logic          illegal_c_insn_i;
  logic          instr_ready_o;
  logic          ex_valid_o;
  logic          ex_ready_i;
  logic          alu_en_o;
  alu_op_e       alu_operator_o;
  logic          alu_use_imm_o;
  logic [31:0]   imm_o;
  logic [4:0]    rs1_o;
  logic [4:0]    rs2_o;
  logic [4:0]    rd_o;
  logic          rf_we_o;
  logic          md_en_o;
  md_op_e        md_operator_o;
  logic          illegal_insn_o;
  logic          ecall_insn_o;
  logic          ebrk_insn_o;
  logic          flush_i;

  exp_t          exp_q[$];     // Accepted but not yet seen at the output
  logic [31:0]   lfsr_q;
  int            n_in;
  int            n_out;
  int            stall_left;   // Model of the MUL/DIV hold-off
  logic          in_trap;      // Model of trap mode
  logic          accepted;     // Transfer at the coming edge

  rvd_id_stage DUT (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .instr_valid_i    (instr_valid_i),
    .instr_rdata_i    (instr_rdata_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .instr_ready_o    (instr_ready_o),
    .ex_valid_o       (ex_valid_o),
    .ex_ready_i       (ex_ready_i),
    .alu_en_o         (alu_en_o),
    .alu_operator_o   (alu_operator_o),
    .alu_use_imm_o    (alu_use_imm_o),
    .imm_o            (imm_o),
    .rs1_o            (rs1_o),
    .rs2_o            (rs2_o),
    .rd_o             (rd_o),
    .rf_we_o          (rf_we_o),
    .md_en_o          (md_en_o),
    .md_operator_o    (md_operator_o),
    .illegal_insn_o   (illegal_insn_o),
    .ecall_insn_o     (ecall_insn_o),
    .ebrk_insn_o      (ebrk_insn_o),
    .flush_i          (flush_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Random source
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois step shifting right
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] gen_word();
    logic [31:0] kind;
    logic [31:0] w;
    kind = rand_bits(3);
    w    = rand_bits(32);                // Random fields with the opcode patched below
    case (kind[2:0])
      3'd0, 3'd1: begin                  // OP with the SUB/SRA form half the time
        w[6:0]   = `RVD_OPC_OP;
        w[31:25] = w[26] ? `RVD_F7_ALT : `RVD_F7_BASE;
      end
      3'd2: w[6:0] = `RVD_OPC_OP_IMM;    // Shift forms mostly illegal here
      3'd3: w[6:0] = `RVD_OPC_LUI;
      3'd4: begin
        w[6:0]   = `RVD_OPC_OP;
        w[31:25] = `RVD_F7_MULDIV;
      end
      3'd5: begin
        w[6:0] = `RVD_OPC_SYSTEM;
        if (w[24:23] != 2'b11) begin     // Mostly a clean ECALL or EBREAK
          w[31:20] = w[21] ? `RVD_IMM_EBREAK : `RVD_IMM_ECALL;
          w[19:7]  = '0;
        end
      end
      3'd6: ;                            // Raw random word
      default: begin                     // SLLI, SRLI and SRAI shapes
        w[6:0]   = `RVD_OPC_OP_IMM;
        w[13:12] = 2'b01;
        w[31:25] = w[30] ? `RVD_F7_ALT : `RVD_F7_BASE;
      end
    endcase
    return w;
  endfunction

  //////////////////////////////
  // Reference decode
  //////////////////////////////

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic md_op_e md_from_f3(input logic [2:0] f3);
    case (f3)
      3'd0:    return MD_MUL;
      3'd1:    return MD_MULH;
      3'd2:    return MD_MULHSU;
      3'd3:    return MD_MULHU;
      3'd4:    return MD_DIV;
      3'd5:    return MD_DIVU;
      3'd6:    return MD_REM;
      default: return MD_REMU;
    endcase
  endfunction

  // Decode before trap suppression
  function automatic decoder_ctrl_t model_decode(input logic [31:0] w, input logic illc);
    decoder_ctrl_t c;
    logic [6:0]    f7;
    logic [2:0]    f3;
    logic          alu_ok;
    alu_op_e       op;
    f7             = w[31:25];
    f3             = w[14:12];
    c              = '0;
    c.alu_operator = ALU_ADD;
    c.md_operator  = MD_MUL;
    c.illegal_insn = 1'b1;         // Until something matches
    alu_ok         = 1'b0;
    op             = alu_from_f3(f3);
    if (!illc) begin
      case (w[6:0])
        `RVD_OPC_OP: begin
          if (f7 == `RVD_F7_MULDIV) begin
            c.md_en        = 1'b1;
            c.md_operator  = md_from_f3(f3);
            c.rf_we        = 1'b1;
            c.illegal_insn = 1'b0;
          end else if (f7 == `RVD_F7_BASE) begin
            alu_ok = 1'b1;
          end else if (f7 == `RVD_F7_ALT && (f3 == 3'd0 || f3 == 3'd5)) begin
            alu_ok = 1'b1;
            op     = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
          end
        end
        `RVD_OPC_OP_IMM: begin
          if (f3 == 3'd1) begin
            alu_ok = (f7 == `RVD_F7_BASE);   // SLLI shamt only
          end else if (f3 == 3'd5) begin
            alu_ok = (f7 == `RVD_F7_BASE) || (f7 == `RVD_F7_ALT);
            if (f7 == `RVD_F7_ALT) op = ALU_SRA;
          end else begin
            alu_ok = 1'b1;
          end
        end
        `RVD_OPC_LUI: begin
          alu_ok = 1'b1;
          op     = ALU_LUI;
        end
        `RVD_OPC_SYSTEM: begin
          if (w[19:7] == '0 && w[31:21] == '0) begin  // imm bit 20 picks EBREAK
            c.illegal_insn = 1'b0;
            c.ecall_insn   = !w[20];
            c.ebrk_insn    = w[20];
          end
        end
        default: ;
      endcase
    end
    if (alu_ok) begin
      c.alu_en       = 1'b1;
      c.alu_operator = op;
      c.alu_use_imm  = (w[6:0] != `RVD_OPC_OP);
      c.rf_we        = 1'b1;
      c.illegal_insn = 1'b0;
    end
    return c;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  // Enables and flags with both operators masked
  task automatic check_ctrl(input decoder_ctrl_t got, input decoder_ctrl_t exp,
                            input logic [31:0] w);
    decoder_ctrl_t g;
    decoder_ctrl_t e;
    g              = got;
    e              = exp;
    g.alu_operator = ALU_ADD;
    e.alu_operator = ALU_ADD;
    g.md_operator  = MD_MUL;
    e.md_operator  = MD_MUL;
    if (g !== e)
      stop_run($sformatf("FAILED at %0d ns: controls %b, expected %b for word %h",
                         $time, g, e, w));
  endtask

  task automatic expect_alu_op(input alu_op_e got, input alu_op_e exp, input logic [31:0] w);
    if (got !== exp)
      stop_run($sformatf("FAILED at %0d ns: alu_operator %s, expected %s for word %h",
                         $time, got.name(), exp.name(), w));
  endtask

  task automatic expect_md_op(input md_op_e got, input md_op_e exp, input logic [31:0] w);
    if (got !== exp)
      stop_run($sformatf("FAILED at %0d ns: md_operator %s, expected %s for word %h",
                         $time, got.name(), exp.name(), w));
  endtask

  task automatic verify_fields(input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [4:0] rd, input logic [31:0] imm, input exp_t e);
    if (rs1 !== e.rs1 || rs2 !== e.rs2 || rd !== e.rd || imm !== e.imm)
      stop_run($sformatf("FAILED at %0d ns: rs1 %0d rs2 %0d rd %0d imm %h, expected %0d %0d %0d %h",
                         $time, rs1, rs2, rd, imm, e.rs1, e.rs2, e.rd, e.imm));
  endtask

  task automatic compare_outputs(input exp_t item);
    decoder_ctrl_t got;
    got.alu_en       = alu_en_o;
    got.alu_operator = alu_operator_o;
    got.alu_use_imm  = alu_use_imm_o;
    got.md_en        = md_en_o;
    got.md_operator  = md_operator_o;
    got.rf_we        = rf_we_o;
    got.ecall_insn   = ecall_insn_o;
    got.ebrk_insn    = ebrk_insn_o;
    got.illegal_insn = illegal_insn_o;
    check_ctrl(got, item.ctrl, item.word);
    expect_alu_op(alu_operator_o, item.ctrl.alu_operator, item.word);
    expect_md_op(md_operator_o, item.ctrl.md_operator, item.word);
    verify_fields(rs1_o, rs2_o, rd_o, imm_o, item);
  endtask

  //////////////////////////////
  // Per-cycle drive and monitor
  //////////////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    if (!instr_valid_i || accepted) begin    // Hold the word until it is taken
      if (n_in < N_INSTR) begin
        r                = rand_bits(2);
        instr_valid_i    = (r[1:0] != 2'b00);
        instr_rdata_i    = gen_word();
        r                = rand_bits(4);
        illegal_c_insn_i = (r[3:0] == 4'd0);
      end else begin
        instr_valid_i = 1'b0;                 // Drain
      end
    end
    r          = rand_bits(2);
    ex_ready_i = (r[1:0] != 2'b00);
    r          = rand_bits(2);
    flush_i    = !flush_i && (r[1:0] == 2'b00);  // Single-cycle pulses
  endtask

  // Runs mid-cycle and sees what the next rising edge acts on
  task automatic monitor_cycle();
    exp_t          item;
    decoder_ctrl_t raw;
    logic          exp_ready;
    exp_ready = (stall_left == 0) && (!ex_valid_o || ex_ready_i);
    if (instr_ready_o !== exp_ready)
      stop_run($sformatf("FAILED at %0d ns: instr_ready_o %b, expected %b",
                         $time, instr_ready_o, exp_ready));
    if (exp_q.size() != ((ex_valid_o === 1'b1) ? 1 : 0))
      stop_run("Output valid does not match the instructions in flight, one was lost or repeated");
    if (ex_valid_o && ex_ready_i) begin
      item = exp_q.pop_front();
      compare_outputs(item);
      n_out++;
    end
    accepted = instr_valid_i && instr_ready_o;
    if (accepted) begin
      raw       = model_decode(instr_rdata_i, illegal_c_insn_i);
      item.word = instr_rdata_i;
      item.ctrl = raw;
      if (in_trap) begin                      // Operators still pass through
        item.ctrl.alu_en       = 1'b0;
        item.ctrl.md_en        = 1'b0;
        item.ctrl.rf_we        = 1'b0;
        item.ctrl.ecall_insn   = 1'b0;
        item.ctrl.ebrk_insn    = 1'b0;
        item.ctrl.illegal_insn = 1'b0;
      end
      item.imm = (item.word[6:0] == `RVD_OPC_LUI) ? {item.word[31:12], 12'd0}
                                                  : {{20{item.word[31]}}, item.word[31:20]};
      item.rs1 = item.word[19:15];
      item.rs2 = item.word[24:20];
      item.rd  = item.word[11:7];
      exp_q.push_back(item);
      n_in++;
    end
    if (stall_left != 0) stall_left--;
    if (accepted && !in_trap && raw.md_en) stall_left = `RVD_MD_CYCLES;
    if (in_trap) begin
      if (flush_i) in_trap = 1'b0;
    end else if (accepted && (raw.illegal_insn || raw.ecall_insn || raw.ebrk_insn)) begin
      in_trap = 1'b1;
    end
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    arst_n_i         = 1'b0;
    instr_valid_i    = 1'b0;
    instr_rdata_i    = '0;
    illegal_c_insn_i = 1'b0;
    ex_ready_i       = 1'b0;
    flush_i          = 1'b0;
    lfsr_q           = 32'h669a;
    n_in             = 0;
    n_out            = 0;
    stall_left       = 0;
    in_trap          = 1'b0;
    accepted         = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    if (ex_valid_o !== 1'b0 || instr_ready_o !== 1'b1 || illegal_insn_o !== 1'b0)
      stop_run("Outputs are not at their reset values during reset");
    arst_n_i = 1'b1;
    while (n_out < N_INSTR) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      monitor_cycle();
    end
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all instructions came out of the stage");
    $display("Finished with errors");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/rvd_pkg.sv
src/rvd_i_decoder.sv
src/rvd_m_decoder.sv
src/rvd_decoder.sv
src/rvd_ctrl_fsm.sv
src/rvd_busy_counter.sv
src/rvd_id_stage.sv
testbench/rvd_chk.sv
testbench/rvd_tb.sv

//--- Makefile
# Verilator build for the decode stage testbench

VERILATOR  ?= verilator
TOP        := rvd_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

# Exit status of the run is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
